//--- dv/ext_bus_checker.sv
// Watches the DUT ports of the external bus testbench. Compares every
// response with the expected values and checks the switch acknowledge delay.

`timescale 1ns/1ps
`default_nettype none

`include "ext_bus_defs.svh"

module ext_bus_checker (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  ext_bus_pkg::reg_req_t reg_req_i,
  input  ext_bus_pkg::reg_rsp_t reg_rsp_i,
  input  ext_bus_pkg::pwr_vec_t switch_n_i,
  input  ext_bus_pkg::pwr_vec_t switch_ack_n_i,
  input  logic                  intr_i,
  input  ext_bus_pkg::data_t    exp_rdata_i,
  input  logic                  exp_error_i,
  input  logic                  exp_cmp_rdata_i,
  input  logic                  intr_chk_i,
  input  logic                  exp_intr_i,
  output int unsigned           error_count_o,
  output int unsigned           rsp_count_o
);

  import ext_bus_pkg::*;

  pwr_vec_t    switch_hist [`SWITCH_ACK_LATENCY];
  logic        busy;
  int unsigned lat_cnt;
  int unsigned exp_lat;
  int unsigned error_cnt = 0;
  int unsigned rsp_cnt = 0;
  data_t       exp_rdata_q;
  logic        exp_error_q;
  logic        exp_cmp_q;
  logic [`EXT_ADDR_WIDTH-1:0] addr_q;

  task automatic flag_error(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    error_cnt++;
  endtask

  // Sampled on the rising edge, before the DUT registers update
  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      busy = 1'b0;
      lat_cnt = 0;
      for (int i = 0; i < `SWITCH_ACK_LATENCY; i++) begin
        switch_hist[i] = '1;
      end
    end else begin
      if (busy) begin
        lat_cnt++;
        if (reg_rsp_i.ready) begin
          busy = 1'b0;
          rsp_cnt++;
          if (lat_cnt != exp_lat) begin
            flag_error($sformatf("ready for %h after %0d cycles, expected %0d",
                                 addr_q, lat_cnt, exp_lat));
          end
          if (reg_rsp_i.error !== exp_error_q) begin
            flag_error($sformatf("error flag for %h is %b, expected %b",
                                 addr_q, reg_rsp_i.error, exp_error_q));
          end
          if (exp_cmp_q && reg_rsp_i.rdata !== exp_rdata_q) begin
            flag_error($sformatf("read of %h returned %h, expected %h",
                                 addr_q, reg_rsp_i.rdata, exp_rdata_q));
          end
        end
      end else if (reg_rsp_i.ready) begin
        flag_error("ready without an outstanding transfer");
      end else if (reg_req_i.valid) begin
        busy        = 1'b1;
        lat_cnt     = 0;
        addr_q      = reg_req_i.addr;
        exp_rdata_q = exp_rdata_i;
        exp_error_q = exp_error_i;
        exp_cmp_q   = exp_cmp_rdata_i;
        // Memory answers after its pipe, register blocks at once
        if (reg_req_i.addr[15:12] == `REGION_RAM) begin
          exp_lat = `SLOW_RAM_LATENCY + 1;
        end else begin
          exp_lat = 1;
        end
      end

      // Ack must repeat the switch request from SWITCH_ACK_LATENCY cycles ago
      if (switch_ack_n_i !== switch_hist[`SWITCH_ACK_LATENCY-1]) begin
        flag_error($sformatf("switch ack %b, expected %b", switch_ack_n_i,
                             switch_hist[`SWITCH_ACK_LATENCY-1]));
      end
      for (int i = `SWITCH_ACK_LATENCY - 1; i > 0; i--) begin
        switch_hist[i] = switch_hist[i-1];
      end
      switch_hist[0] = switch_n_i;

      if (intr_chk_i && intr_i !== exp_intr_i) begin
        flag_error($sformatf("intr_o is %b, expected %b", intr_i, exp_intr_i));
      end
    end
  end

  assign error_count_o = error_cnt;
  assign rsp_count_o   = rsp_cnt;

endmodule

`default_nettype wire

//--- dv/tb_ext_bus.sv
// Testbench top for the external register bus. Reads steps from
// dv/test_input.txt, drives them into the DUT and lets the checker compare.

`timescale 1ns/1ps
`default_nettype none

`include "ext_bus_defs.svh"

module tb_ext_bus;

  import ext_bus_pkg::*;

  typedef struct packed {
    logic [7:0]                 op;
    logic [`EXT_ADDR_WIDTH-1:0] addr;
    data_t                      data;
    logic [`EXT_STRB_WIDTH-1:0] strb;
    data_t                      exp_rdata;
    logic                       exp_error;
  } step_t;

  logic        clk;
  logic        arst_n;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;
  ext_vec_t    ext_intr;
  pwr_vec_t    switch_n;
  pwr_vec_t    switch_ack_n;
  logic        intr;
  data_t       exp_rdata;
  logic        exp_error;
  logic        exp_cmp_rdata;
  logic        intr_chk;
  logic        exp_intr;
  int unsigned chk_errors;
  int unsigned rsp_count;
  int unsigned drive_errors = 0;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;
  step_t       steps[$];

  ext_bus_top ext_bus_top_i (
    .clk_i                    (clk),
    .arst_n_i                 (arst_n),
    .reg_req_i                (reg_req),
    .reg_rsp_o                (reg_rsp),
    .ext_intr_i               (ext_intr),
    .powergate_switch_n_o     (switch_n),
    .powergate_switch_ack_n_o (switch_ack_n),
    .intr_o                   (intr)
  );

  ext_bus_checker ext_bus_checker_i (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .reg_req_i       (reg_req),
    .reg_rsp_i       (reg_rsp),
    .switch_n_i      (switch_n),
    .switch_ack_n_i  (switch_ack_n),
    .intr_i          (intr),
    .exp_rdata_i     (exp_rdata),
    .exp_error_i     (exp_error),
    .exp_cmp_rdata_i (exp_cmp_rdata),
    .intr_chk_i      (intr_chk),
    .exp_intr_i      (exp_intr),
    .error_count_o   (chk_errors),
    .rsp_count_o     (rsp_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic load_steps(output logic ok, output int unsigned n_xfer,
                            output int unsigned n_wait);
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] rd;
    logic        err;
    n_xfer = 0;
    n_wait = 0;
    fd = $fopen("dv/test_input.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h %h %h %h", op, addr, data, strb, rd, err);
          if (n == 6) begin
            steps.push_back({op, addr, data, strb, rd, err});
            if (op == "W" || op == "R") begin
              n_xfer++;
            end else if (op == "D") begin
              n_wait += data;
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic bus_transfer(input step_t s);
    int unsigned waited;
    @(negedge clk);
    reg_req.valid = 1'b1;
    reg_req.write = (s.op == "W");
    reg_req.addr  = s.addr;
    reg_req.wdata = s.data;
    reg_req.wstrb = s.strb;
    exp_rdata     = s.exp_rdata;
    exp_error     = s.exp_error;
    exp_cmp_rdata = (s.op == "R");
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!reg_rsp.ready && waited < 20);
    if (!reg_rsp.ready) begin
      $display("No ready for the transfer to %h within 20 cycles", s.addr);
      drive_errors++;
    end
    reg_req = '0;
  endtask

  task automatic pulse_ext_intr(input ext_vec_t lines);
    @(negedge clk);
    ext_intr = lines;
    @(negedge clk);
    ext_intr = '0;
  endtask

  task automatic request_intr_check(input logic level);
    @(negedge clk);
    exp_intr = level;
    intr_chk = 1'b1;
    @(negedge clk);
    intr_chk = 1'b0;
  endtask

  task automatic run_step(input step_t s);
    case (s.op)
      "W", "R": bus_transfer(s);
      "I": pulse_ext_intr(s.data[`EXT_INTR_NUM-1:0]);
      "D": repeat (s.data) @(negedge clk);
      "C": request_intr_check(s.exp_rdata[0]);
      default: begin
        $display("Unknown step code %c in the stimulus file", s.op);
        drive_errors++;
      end
    endcase
  endtask

  initial begin
    logic        ok;
    int unsigned n_xfer;
    int unsigned n_wait;
    arst_n        = 1'b0;
    reg_req       = '0;
    ext_intr      = '0;
    exp_rdata     = '0;
    exp_error     = 1'b0;
    exp_cmp_rdata = 1'b0;
    intr_chk      = 1'b0;
    exp_intr      = 1'b0;
    load_steps(ok, n_xfer, n_wait);
    if (!ok || steps.size() == 0) begin
      $display("Stimulus file dv/test_input.txt is missing or holds no steps");
      $display("Some tests failed");
      $finish;
    end else begin
      cycle_limit = n_xfer * 20 + n_wait + 200;
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
      foreach (steps[i]) begin
        run_step(steps[i]);
      end
      repeat (5) @(negedge clk);
      if (rsp_count != n_xfer) begin
        $display("Saw %0d responses for %0d transfers", rsp_count, n_xfer);
        drive_errors++;
      end
      $display("Errors: checker %0d, driver %0d, responses checked %0d",
               chk_errors, drive_errors, rsp_count);
      if (chk_errors == 0 && drive_errors == 0) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- dv/test_input.txt
# op addr wdata wstrb exp_rdata exp_err, numbers in hex
# op: W write, R read, I ext interrupt pulse (wdata), D wait (wdata cycles), C intr_o check
C 00000000 00000000 0 00000000 0
R 00002000 00000000 0 00000000 0
R 00002004 00000000 0 00000000 0
R 00001000 00000000 0 0000000f 0
R 00001004 00000000 0 0000000f 0
W 00000000 11223344 f 00000000 0
W 00000004 aabbccdd f 00000000 0
W 00000ffc 01234567 f 00000000 0
W 00000008 cafef00d f 00000000 0
W 00000000 0000ee00 2 00000000 0
W 00000004 99000000 8 00000000 0
W 00000ffc 0000beef 3 00000000 0
W 00000008 00550066 5 00000000 0
R 00000000 00000000 0 1122ee44 0
R 00000004 00000000 0 99bbccdd 0
R 00000ffc 00000000 0 0123beef 0
R 00000008 00000000 0 ca55f066 0
R 00003000 00000000 0 00000000 1
W 0000f010 deadbeef f 00000000 1
R 00005004 00000000 0 00000000 1
W 00001000 0000000a f 00000000 0
R 00001004 00000000 0 0000000f 0
D 00000000 00000004 0 00000000 0
R 00001004 00000000 0 0000000f 0
D 00000000 0000000c 0 00000000 0
R 00001004 00000000 0 0000000a 0
R 00002000 00000000 0 00000028 0
C 00000000 00000000 0 00000000 0
W 00002000 0000007f f 00000000 0
I 00000000 00000005 0 00000000 0
C 00000000 00000000 0 00000000 0
R 00002000 00000000 0 00000005 0
W 00002000 0000007f f 00000000 0
W 00002004 00000007 f 00000000 0
R 00002004 00000000 0 00000007 0
I 00000000 00000002 0 00000000 0
C 00000000 00000000 0 00000001 0
R 00002000 00000000 0 00000002 0
W 00002000 00000002 f 00000000 0
C 00000000 00000000 0 00000000 0
W 00002004 00000078 f 00000000 0
W 00001000 0000000f f 00000000 0
D 00000000 00000014 0 00000000 0
C 00000000 00000000 0 00000001 0
R 00002000 00000000 0 00000028 0
R 00001004 00000000 0 0000000f 0
W 00002000 0000007f f 00000000 0
C 00000000 00000000 0 00000000 0
R 00002000 00000000 0 00000000 0

//--- hdl/ext_bus_ctrl.sv
// Register bus front end. Decodes the region of each host transfer,
// strobes the addressed block and returns a single-cycle ready.

`timescale 1ns/1ps
`default_nettype none

`include "ext_bus_defs.svh"

module ext_bus_ctrl (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  ext_bus_pkg::reg_req_t    reg_req_i,
  output ext_bus_pkg::reg_rsp_t    reg_rsp_o,
  output ext_bus_pkg::periph_req_t ram_req_o,
  output ext_bus_pkg::periph_req_t pwr_req_o,
  output ext_bus_pkg::periph_req_t intr_req_o,
  input  ext_bus_pkg::ram_rsp_t    ram_rsp_i,
  input  ext_bus_pkg::data_t       pwr_rdata_i,
  input  ext_bus_pkg::data_t       intr_rdata_i
);

  import ext_bus_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_RESP
  } state_e;

  state_e                        state_q;
  state_e                        state_d;
  reg_rsp_t                      rsp_q;
  reg_rsp_t                      rsp_d;
  logic [`EXT_REGION_WIDTH-1:0]  region;
  logic                          hit_ram;
  logic                          hit_pwr;
  logic                          hit_intr;
  logic                          accept;
  periph_req_t                   req_base;

  // Address decode
  assign region   = reg_req_i.addr[`EXT_REGION_LSB +: `EXT_REGION_WIDTH];
  assign hit_ram  = (region == `REGION_RAM);
  assign hit_pwr  = (region == `REGION_PWR);
  assign hit_intr = (region == `REGION_INTR);

  // Only the first cycle of a held transfer is taken
  assign accept = (state_q == ST_IDLE) && reg_req_i.valid;

  always_comb begin
    req_base        = '0;
    req_base.write  = reg_req_i.write;
    req_base.offset = reg_req_i.addr[2 +: RAM_OFFSET_WIDTH];
    req_base.wdata  = reg_req_i.wdata;
    req_base.wstrb  = reg_req_i.wstrb;

    ram_req_o         = req_base;
    ram_req_o.strobe  = accept && hit_ram;
    pwr_req_o         = req_base;
    pwr_req_o.strobe  = accept && hit_pwr;
    intr_req_o        = req_base;
    intr_req_o.strobe = accept && hit_intr;
  end

  always_comb begin
    state_d = state_q;
    rsp_d   = '0;
    case (state_q)
      ST_IDLE: begin
        if (reg_req_i.valid) begin
          if (hit_ram) begin
            state_d = ST_WAIT;
          end else begin
            // Register blocks answer in the same cycle, unmapped gets an error
            state_d     = ST_RESP;
            rsp_d.ready = 1'b1;
            rsp_d.error = !(hit_pwr || hit_intr);
            if (hit_pwr) begin
              rsp_d.rdata = pwr_rdata_i;
            end else if (hit_intr) begin
              rsp_d.rdata = intr_rdata_i;
            end
          end
        end
      end
      ST_WAIT: begin
        if (ram_rsp_i.rvalid) begin
          state_d     = ST_RESP;
          rsp_d.ready = 1'b1;
          rsp_d.rdata = ram_rsp_i.rdata;
        end
      end
      ST_RESP: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      rsp_q   <= '0;
    end else begin
      state_q <= state_d;
      rsp_q   <= rsp_d;
    end
  end

  assign reg_rsp_o = rsp_q;

endmodule

`default_nettype wire

//--- hdl/ext_bus_defs.svh
// Widths, sizes, latencies and region codes of the external register bus.
// Included by the package and by every block that sizes logic from it.

`ifndef EXT_BUS_DEFS_SVH
`define EXT_BUS_DEFS_SVH

// Bus word format
`define EXT_ADDR_WIDTH 32
`define EXT_DATA_WIDTH 32
`define EXT_STRB_WIDTH 4

// Slow memory
`define SLOW_RAM_WORDS 1024
`define SLOW_RAM_LATENCY 3

// Power switch emulation
`define SWITCH_ACK_LATENCY 15
`define PWR_DOMAINS 4

// Interrupt sources, external ones in the low bits
`define EXT_INTR_NUM 3
`define INTR_SRC_NUM (`EXT_INTR_NUM + `PWR_DOMAINS)

// Region field of the address, codes below
`define EXT_REGION_LSB 12
`define EXT_REGION_WIDTH 4
`define REGION_RAM 4'd0
`define REGION_PWR 4'd1
`define REGION_INTR 4'd2

`endif

//--- hdl/ext_bus_pkg.sv
// Bus request/response types shared by the RTL blocks and the testbench.
// Compile before any module of the external bus.

`default_nettype none

`include "ext_bus_defs.svh"

package ext_bus_pkg;

  localparam int unsigned RAM_OFFSET_WIDTH = $clog2(`SLOW_RAM_WORDS);

  typedef logic [`EXT_DATA_WIDTH-1:0] data_t;
  typedef logic [`PWR_DOMAINS-1:0] pwr_vec_t;
  typedef logic [`EXT_INTR_NUM-1:0] ext_vec_t;
  typedef logic [`INTR_SRC_NUM-1:0] intr_vec_t;

  // Host side transfer, held until ready
  typedef struct packed {
    logic                       valid;
    logic                       write;
    logic [`EXT_ADDR_WIDTH-1:0] addr;
    data_t                      wdata;
    logic [`EXT_STRB_WIDTH-1:0] wstrb;
  } reg_req_t;

  // Ready is a single-cycle pulse
  typedef struct packed {
    logic  ready;
    logic  error;
    data_t rdata;
  } reg_rsp_t;

  // Routed to one block, strobe lasts one cycle
  typedef struct packed {
    logic                        strobe;
    logic                        write;
    logic [RAM_OFFSET_WIDTH-1:0] offset;
    data_t                       wdata;
    logic [`EXT_STRB_WIDTH-1:0]  wstrb;
  } periph_req_t;

  typedef struct packed {
    logic  rvalid;
    data_t rdata;
  } ram_rsp_t;

endpackage

`default_nettype wire

//--- hdl/ext_bus_top.sv
// Top of the external register bus. The host drives reg_req_i; the
// control block routes each transfer to the memory, switches or interrupts.

`timescale 1ns/1ps
`default_nettype none

module ext_bus_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  ext_bus_pkg::reg_req_t reg_req_i,
  output ext_bus_pkg::reg_rsp_t reg_rsp_o,
  input  ext_bus_pkg::ext_vec_t ext_intr_i,
  output ext_bus_pkg::pwr_vec_t powergate_switch_n_o,
  output ext_bus_pkg::pwr_vec_t powergate_switch_ack_n_o,
  output logic                  intr_o
);

  import ext_bus_pkg::*;

  periph_req_t ram_req;
  periph_req_t pwr_req;
  periph_req_t intr_req;
  ram_rsp_t    ram_rsp;
  data_t       pwr_rdata;
  data_t       intr_rdata;
  pwr_vec_t    pwr_event;

  ext_bus_ctrl ext_bus_ctrl_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .reg_req_i    (reg_req_i),
    .reg_rsp_o    (reg_rsp_o),
    .ram_req_o    (ram_req),
    .pwr_req_o    (pwr_req),
    .intr_req_o   (intr_req),
    .ram_rsp_i    (ram_rsp),
    .pwr_rdata_i  (pwr_rdata),
    .intr_rdata_i (intr_rdata)
  );

  slow_ram slow_ram_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (ram_req),
    .rsp_o    (ram_rsp)
  );

  power_switch_emu power_switch_emu_i (
    .clk_i                    (clk_i),
    .arst_n_i                 (arst_n_i),
    .req_i                    (pwr_req),
    .rdata_o                  (pwr_rdata),
    .powergate_switch_n_o     (powergate_switch_n_o),
    .powergate_switch_ack_n_o (powergate_switch_ack_n_o),
    .pwr_event_o              (pwr_event)
  );

  // Ack transitions feed the upper interrupt sources
  intr_collect intr_collect_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (intr_req),
    .rdata_o     (intr_rdata),
    .ext_intr_i  (ext_intr_i),
    .pwr_event_i (pwr_event),
    .intr_o      (intr_o)
  );

endmodule

`default_nettype wire

//--- hdl/intr_collect.sv
// Interrupt collector. Rising edges on external lines and power events
// set pending bits; the masked pending bits are ORed onto intr_o.

`timescale 1ns/1ps
`default_nettype none

`include "ext_bus_defs.svh"

module intr_collect (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  ext_bus_pkg::periph_req_t req_i,
  output ext_bus_pkg::data_t       rdata_o,
  input  ext_bus_pkg::ext_vec_t    ext_intr_i,
  input  ext_bus_pkg::pwr_vec_t    pwr_event_i,
  output logic                     intr_o
);

  import ext_bus_pkg::*;

  intr_vec_t src;
  intr_vec_t src_q;
  intr_vec_t rise;
  intr_vec_t clr;
  intr_vec_t pending_q;
  intr_vec_t mask_q;
  logic      wr_en;

  // External lines low, power events above
  assign src  = {pwr_event_i, ext_intr_i};
  assign rise = src & ~src_q;

  assign wr_en = req_i.strobe && req_i.write && req_i.wstrb[0];
  assign clr   = (wr_en && req_i.offset == 'd0) ? req_i.wdata[`INTR_SRC_NUM-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q     <= '0;
      pending_q <= '0;
      mask_q    <= '0;
    end else begin
      src_q <= src;
      // a new edge wins over a clear in the same cycle
      pending_q <= (pending_q & ~clr) | rise;
      if (wr_en && req_i.offset == 'd1) begin
        mask_q <= req_i.wdata[`INTR_SRC_NUM-1:0];
      end
    end
  end

  assign intr_o = |(pending_q & mask_q);

  always_comb begin
    rdata_o = '0;
    if (req_i.offset == 'd0) begin
      rdata_o[`INTR_SRC_NUM-1:0] = pending_q;
    end else if (req_i.offset == 'd1) begin
      rdata_o[`INTR_SRC_NUM-1:0] = mask_q;
    end
  end

endmodule

`default_nettype wire

//--- hdl/power_switch_emu.sv
// Power-domain switch emulation. Offset 0 holds the active-low switch
// requests, offset 1 reads the acknowledges, which trail by a fixed delay.

`timescale 1ns/1ps
`default_nettype none

`include "ext_bus_defs.svh"

module power_switch_emu (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  ext_bus_pkg::periph_req_t req_i,
  output ext_bus_pkg::data_t       rdata_o,
  output ext_bus_pkg::pwr_vec_t    powergate_switch_n_o,
  output ext_bus_pkg::pwr_vec_t    powergate_switch_ack_n_o,
  output ext_bus_pkg::pwr_vec_t    pwr_event_o
);

  import ext_bus_pkg::*;

  pwr_vec_t switch_n_q;
  // One stage beyond the latency keeps the previous ack for edge detection
  pwr_vec_t ack_pipe_q [`SWITCH_ACK_LATENCY+1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      switch_n_q <= '1;
    end else if (req_i.strobe && req_i.write && req_i.offset == '0 && req_i.wstrb[0]) begin
      switch_n_q <= req_i.wdata[`PWR_DOMAINS-1:0];
    end
  end

  // Switch cells settle SWITCH_ACK_LATENCY cycles after the request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i <= `SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i] <= '1;
      end
    end else begin
      ack_pipe_q[0] <= switch_n_q;
      for (int i = 0; i < `SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i+1] <= ack_pipe_q[i];
      end
    end
  end

  assign powergate_switch_n_o     = switch_n_q;
  assign powergate_switch_ack_n_o = ack_pipe_q[`SWITCH_ACK_LATENCY-1];
  assign pwr_event_o = ack_pipe_q[`SWITCH_ACK_LATENCY-1] ^ ack_pipe_q[`SWITCH_ACK_LATENCY];

  always_comb begin
    rdata_o = '0;
    if (req_i.offset == 'd0) begin
      rdata_o[`PWR_DOMAINS-1:0] = switch_n_q;
    end else if (req_i.offset == 'd1) begin
      rdata_o[`PWR_DOMAINS-1:0] = powergate_switch_ack_n_o;
    end
  end

endmodule

`default_nettype wire

//--- hdl/slow_ram.sv
// Word memory behind the bus with byte write strobes.
// Every access answers with rvalid a fixed number of cycles after its strobe.

`timescale 1ns/1ps
`default_nettype none

`include "ext_bus_defs.svh"

module slow_ram (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  ext_bus_pkg::periph_req_t req_i,
  output ext_bus_pkg::ram_rsp_t    rsp_o
);

  import ext_bus_pkg::*;

  data_t    mem [`SLOW_RAM_WORDS];
  ram_rsp_t pipe_q [`SLOW_RAM_LATENCY];

  // Byte-lane writes
  always_ff @(posedge clk_i) begin
    if (req_i.strobe && req_i.write) begin
      for (int b = 0; b < `EXT_STRB_WIDTH; b++) begin
        if (req_i.wstrb[b]) begin
          mem[req_i.offset][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Latency pipe, several accesses may be in flight
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `SLOW_RAM_LATENCY; i++) begin
        pipe_q[i] <= '0;
      end
    end else begin
      pipe_q[0].rvalid <= req_i.strobe;
      pipe_q[0].rdata  <= mem[req_i.offset];
      for (int i = 1; i < `SLOW_RAM_LATENCY; i++) begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end
  end

  assign rsp_o = pipe_q[`SLOW_RAM_LATENCY-1];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the external bus testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
  --top-module tb_ext_bus -Mdir obj_dir -o sim_ext_bus
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_ext_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- sources.f
+incdir+hdl
hdl/ext_bus_pkg.sv
hdl/ext_bus_ctrl.sv
hdl/slow_ram.sv
hdl/power_switch_emu.sv
hdl/intr_collect.sv
hdl/ext_bus_top.sv
dv/ext_bus_checker.sv
dv/tb_ext_bus.sv
